// ==== rtl/vlb_params.svh ====
`ifndef VLB_PARAMS_SVH
`define VLB_PARAMS_SVH

// fabric size
`define VLB_TOR_NUM         8
`define VLB_SLOT_NUM        2
`define VLB_OCS_NUM         2

// index of this tor in the rotation
`define VLB_MY_TOR_ID       0

// per destination buffer budget in one slot
`define VLB_SLOT_MAX_BYTES  32'h0004_0000

`define VLB_BYTE_W          32

`endif

// ==== rtl/vlb_queue_pkg.sv ====
`include "vlb_params.svh"

package vlb_queue_pkg;

    typedef logic [`VLB_BYTE_W-1:0] byte_cnt_t;

    // one byte count per destination queue
    typedef byte_cnt_t [`VLB_TOR_NUM-1:0] queue_vec_t;

    // relay offer from a neighbour on one uplink
    typedef struct packed {
        queue_vec_t bytes;
        byte_cnt_t  capacity;
    } offer_t;

    // queue sizes reported by the packet buffer
    typedef struct packed {
        queue_vec_t local_size;
        queue_vec_t unlocal_size;
    } queue_snap_t;

endpackage

// ==== rtl/vlb_topo_pkg.sv ====
`include "vlb_params.svh"

package vlb_topo_pkg;

    typedef logic [$clog2(`VLB_TOR_NUM)-1:0]  tor_id_t;
    typedef logic [$clog2(`VLB_SLOT_NUM)-1:0] slot_id_t;

    // neighbours reached in the next slot
    typedef struct packed {
        tor_id_t even_hop;
        tor_id_t odd_hop;
    } next_hop_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        GRANT = 2'd1,
        WAIT  = 2'd2
    } arb_state_t;

endpackage

// ==== rtl/vlb_queue_snapshot.sv ====
`timescale 1ns/1ps

module vlb_queue_snapshot (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_slot_start,
    input  vlb_topo_pkg::slot_id_t     i_slot_id,
    input  logic                       i_check_queue_resp_ready,
    input  vlb_queue_pkg::queue_snap_t i_queue_snap,
    output logic                       o_check_queue_req_valid,
    output logic                       o_snap_pulse,
    output vlb_queue_pkg::queue_snap_t o_snap,
    output vlb_topo_pkg::slot_id_t     o_slot_id
);
    import vlb_topo_pkg::*;

    logic     slot_start_q;
    slot_id_t slot_id_q;
    logic [2:0] resp_sync;
    logic     resp_rise;

    ////////////////////////////////////////////////////////////
    // slot start capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            slot_start_q <= 1'b0;
            slot_id_q    <= '0;
        end else begin
            slot_start_q <= i_slot_start;
            if (i_slot_start) begin
                slot_id_q <= i_slot_id;
            end
        end
    end

    // request held until the response is fully synchronised
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_check_queue_req_valid <= 1'b0;
        end else if (resp_sync[2]) begin
            o_check_queue_req_valid <= 1'b0;
        end else if (slot_start_q) begin
            o_check_queue_req_valid <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // response from the buffer clock domain
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            resp_sync <= 3'b000;
        end else begin
            resp_sync <= {resp_sync[1:0], i_check_queue_resp_ready};
        end
    end

    assign resp_rise = resp_sync[1] & ~resp_sync[2];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_snap_pulse <= 1'b0;
            o_slot_id    <= '0;
        end else begin
            o_snap_pulse <= resp_rise;
            if (resp_rise) begin
                o_slot_id <= slot_id_q;
            end
        end
    end

    // queue sizes are stable while the response level is high
    always_ff @(posedge i_clk) begin
        if (resp_rise) begin
            o_snap <= i_queue_snap;
        end
    end

endmodule

// ==== rtl/vlb_next_hop.sv ====
`timescale 1ns/1ps
`include "vlb_params.svh"

module vlb_next_hop (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_snap_pulse,
    input  vlb_topo_pkg::slot_id_t  i_slot_id,
    output vlb_topo_pkg::next_hop_t o_next_hop
);
    import vlb_topo_pkg::*;

    localparam int TOR_NUM  = `VLB_TOR_NUM;
    localparam int SLOT_NUM = `VLB_SLOT_NUM;
    localparam int MY_ID    = `VLB_MY_TOR_ID;

    slot_id_t next_slot;
    int       hop_step;
    tor_id_t  even_id;
    tor_id_t  odd_id;

    // next slot wraps over the ocs cycle
    always_comb begin
        if (int'(i_slot_id) == SLOT_NUM - 1) begin
            next_slot = '0;
        end else begin
            next_slot = i_slot_id + 1'b1;
        end
    end

    // rotation distance in slot s is 2s+1
    assign hop_step = (2 * int'(next_slot) + 1) % TOR_NUM;

    // even ocs rotates forward, odd ocs backward
    assign even_id = tor_id_t'((MY_ID + hop_step) % TOR_NUM);
    assign odd_id  = tor_id_t'((MY_ID + TOR_NUM - hop_step) % TOR_NUM);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_next_hop <= '0;
        end else if (i_snap_pulse) begin
            o_next_hop.even_hop <= even_id;
            o_next_hop.odd_hop  <= odd_id;
        end
    end

endmodule

// ==== rtl/vlb_offer_arbiter.sv ====
`timescale 1ns/1ps
`include "vlb_params.svh"

module vlb_offer_arbiter (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_offer0_valid,
    input  vlb_queue_pkg::offer_t i_offer0,
    input  logic                  i_offer1_valid,
    input  vlb_queue_pkg::offer_t i_offer1,
    input  logic                  i_relay_done,
    output logic                  o_grant_valid,
    output logic                  o_grant_port,
    output vlb_queue_pkg::offer_t o_grant_offer
);
    import vlb_queue_pkg::*;
    import vlb_topo_pkg::*;

    localparam int PORT_NUM = `VLB_OCS_NUM;

    arb_state_t          state;
    arb_state_t          state_nxt;
    logic [PORT_NUM-1:0] offer_valid;
    offer_t              offer_in [PORT_NUM];
    offer_t              offer_q  [PORT_NUM];
    logic [PORT_NUM-1:0] pending;
    logic                grant_take;
    logic                pick_port;

    assign offer_valid = {i_offer1_valid, i_offer0_valid};
    assign offer_in[0] = i_offer0;
    assign offer_in[1] = i_offer1;

    ////////////////////////////////////////////////////////////
    // pending offers per uplink
    ////////////////////////////////////////////////////////////
    // a new offer overrides the clear of a port being granted
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pending <= '0;
        end else begin
            for (int p = 0; p < PORT_NUM; p++) begin
                if (offer_valid[p]) begin
                    pending[p] <= 1'b1;
                end else if (grant_take && (int'(pick_port) == p)) begin
                    pending[p] <= 1'b0;
                end
            end
        end
    end

    // later offer from the same port replaces the stored one
    always_ff @(posedge i_clk) begin
        for (int p = 0; p < PORT_NUM; p++) begin
            if (offer_valid[p]) begin
                offer_q[p] <= offer_in[p];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // grant fsm with port 0 first
    ////////////////////////////////////////////////////////////
    assign pick_port  = ~pending[0];
    assign grant_take = (state == IDLE) && (|pending);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (|pending) state_nxt = GRANT;
            GRANT:   state_nxt = WAIT;
            WAIT:    if (i_relay_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state        <= IDLE;
            o_grant_port <= 1'b0;
        end else begin
            state <= state_nxt;
            if (grant_take) begin
                o_grant_port <= pick_port;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (grant_take) begin
            o_grant_offer <= offer_q[pick_port];
        end
    end

    assign o_grant_valid = (state == GRANT);

endmodule

// ==== rtl/vlb_relay_alloc.sv ====
`timescale 1ns/1ps
`include "vlb_params.svh"

module vlb_relay_alloc (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_snap_pulse,
    input  vlb_queue_pkg::queue_snap_t i_snap,
    input  vlb_topo_pkg::next_hop_t    i_next_hop,
    input  logic                       i_grant_valid,
    input  logic                       i_grant_port,
    input  vlb_queue_pkg::offer_t      i_grant_offer,
    output logic                       o_relay_valid,
    output logic                       o_relay_port,
    output vlb_queue_pkg::queue_vec_t  o_relay
);
    import vlb_queue_pkg::*;
    import vlb_topo_pkg::*;

    localparam byte_cnt_t SLOT_MAX = `VLB_SLOT_MAX_BYTES;

    queue_vec_t budget;
    tor_id_t    hop_a;
    tor_id_t    hop_b;
    byte_cnt_t  cap;
    byte_cnt_t  cap_left;
    byte_cnt_t  relay_a;
    byte_cnt_t  relay_b;
    queue_vec_t relay_nxt;

    function automatic byte_cnt_t min2(input byte_cnt_t x, input byte_cnt_t y);
        return (x < y) ? x : y;
    endfunction

    // free space for one destination saturates at zero
    function automatic byte_cnt_t slot_budget(input byte_cnt_t loc, input byte_cnt_t unloc);
        logic [`VLB_BYTE_W:0] used;
        used = {1'b0, loc} + {1'b0, unloc};
        if (used >= {1'b0, SLOT_MAX}) begin
            return '0;
        end else begin
            return SLOT_MAX - used[`VLB_BYTE_W-1:0];
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // grant computation
    ////////////////////////////////////////////////////////////
    assign hop_a = i_next_hop.even_hop;
    assign hop_b = i_next_hop.odd_hop;
    assign cap   = i_grant_offer.capacity;

    assign relay_a  = min2(min2(i_grant_offer.bytes[hop_a], cap), budget[hop_a]);
    // relay_a never exceeds cap
    assign cap_left = cap - relay_a;
    assign relay_b  = min2(min2(i_grant_offer.bytes[hop_b], cap_left), budget[hop_b]);

    always_comb begin
        relay_nxt        = '0;
        relay_nxt[hop_a] = relay_a;
        relay_nxt[hop_b] = relay_b;
    end

    ////////////////////////////////////////////////////////////
    // budgets
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            budget <= '0;
        end else if (i_snap_pulse) begin
            for (int q = 0; q < `VLB_TOR_NUM; q++) begin
                budget[q] <= slot_budget(i_snap.local_size[q], i_snap.unlocal_size[q]);
            end
        end else if (i_grant_valid) begin
            budget[hop_a] <= budget[hop_a] - relay_a;
            budget[hop_b] <= budget[hop_b] - relay_b;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_relay_valid <= 1'b0;
            o_relay_port  <= 1'b0;
        end else begin
            o_relay_valid <= i_grant_valid;
            if (i_grant_valid) begin
                o_relay_port <= i_grant_port;
            end
        end
    end

    // vector is zero outside the valid cycle
    always_ff @(posedge i_clk) begin
        o_relay <= i_grant_valid ? relay_nxt : '0;
    end

endmodule

// ==== rtl/vlb_relay_ctrl.sv ====
`timescale 1ns/1ps

module vlb_relay_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_slot_start,
    input  vlb_topo_pkg::slot_id_t     i_slot_id,
    output logic                       o_check_queue_req_valid,
    input  logic                       i_check_queue_resp_ready,
    input  vlb_queue_pkg::queue_snap_t i_queue_snap,
    input  logic                       i_offer0_valid,
    input  vlb_queue_pkg::offer_t      i_offer0,
    input  logic                       i_offer1_valid,
    input  vlb_queue_pkg::offer_t      i_offer1,
    output logic                       o_relay_valid,
    output logic                       o_relay_port,
    output vlb_queue_pkg::queue_vec_t  o_relay
);
    import vlb_queue_pkg::*;
    import vlb_topo_pkg::*;

    logic        snap_pulse;
    queue_snap_t snap;
    slot_id_t    slot_id;
    next_hop_t   next_hop;
    logic        grant_valid;
    logic        grant_port;
    offer_t      grant_offer;
    logic        relay_done;

    assign o_relay_valid = relay_done;

    vlb_queue_snapshot u_vlb_queue_snapshot (
        .i_clk                    (i_clk),
        .i_rst                    (i_rst),
        .i_slot_start             (i_slot_start),
        .i_slot_id                (i_slot_id),
        .i_check_queue_resp_ready (i_check_queue_resp_ready),
        .i_queue_snap             (i_queue_snap),
        .o_check_queue_req_valid  (o_check_queue_req_valid),
        .o_snap_pulse             (snap_pulse),
        .o_snap                   (snap),
        .o_slot_id                (slot_id)
    );

    vlb_next_hop u_vlb_next_hop (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_snap_pulse (snap_pulse),
        .i_slot_id    (slot_id),
        .o_next_hop   (next_hop)
    );

    vlb_offer_arbiter u_vlb_offer_arbiter (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_offer0_valid (i_offer0_valid),
        .i_offer0       (i_offer0),
        .i_offer1_valid (i_offer1_valid),
        .i_offer1       (i_offer1),
        .i_relay_done   (relay_done),
        .o_grant_valid  (grant_valid),
        .o_grant_port   (grant_port),
        .o_grant_offer  (grant_offer)
    );

    vlb_relay_alloc u_vlb_relay_alloc (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_snap_pulse  (snap_pulse),
        .i_snap        (snap),
        .i_next_hop    (next_hop),
        .i_grant_valid (grant_valid),
        .i_grant_port  (grant_port),
        .i_grant_offer (grant_offer),
        .o_relay_valid (relay_done),
        .o_relay_port  (o_relay_port),
        .o_relay       (o_relay)
    );

endmodule

// ==== sim/vlb_relay_checker.sv ====
`timescale 1ns/1ps

module vlb_relay_checker (
    input logic                      i_clk,
    input logic                      i_rst,
    input logic                      i_req_valid,
    input logic                      i_resp_ready,
    input logic                      i_relay_valid,
    input vlb_queue_pkg::queue_vec_t i_relay,
    input vlb_topo_pkg::next_hop_t   i_next_hop
);
    import vlb_queue_pkg::*;

    int         assert_fail_cnt = 0;
    queue_vec_t off_hop;

    // relay entries outside the two neighbours
    always_comb begin
        off_hop                      = i_relay;
        off_hop[i_next_hop.even_hop] = '0;
        off_hop[i_next_hop.odd_hop]  = '0;
    end

    ////////////////////////////////////////////////////////////
    // request and grant protocol
    ////////////////////////////////////////////////////////////
    a_req_until_resp: assert property (
        @(posedge i_clk) disable iff (i_rst)
        $fell(i_req_valid) |-> $past(i_resp_ready, 3)
    ) else begin
        assert_fail_cnt = assert_fail_cnt + 1;
        $error("queue request dropped before the response was seen");
    end

    a_relay_one_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_relay_valid |-> !$past(i_relay_valid)
    ) else begin
        assert_fail_cnt = assert_fail_cnt + 1;
        $error("relay valid held longer than one cycle");
    end

    a_relay_on_hops: assert property (
        @(posedge i_clk) disable iff (i_rst)
        off_hop == '0
    ) else begin
        assert_fail_cnt = assert_fail_cnt + 1;
        $error("relay bytes outside the next hop queues");
    end

endmodule

// ==== sim/tb_vlb_relay_ctrl.sv ====
`timescale 1ns/1ps
`include "vlb_params.svh"

module tb_vlb_relay_ctrl;
    import vlb_queue_pkg::*;
    import vlb_topo_pkg::*;

    localparam int        TOR_NUM         = `VLB_TOR_NUM;
    localparam int        SLOT_NUM        = `VLB_SLOT_NUM;
    localparam int        MY_ID           = `VLB_MY_TOR_ID;
    localparam byte_cnt_t SLOT_MAX        = `VLB_SLOT_MAX_BYTES;
    localparam int        ROW_NUM         = 11;
    localparam int        WATCHDOG_CYCLES = ROW_NUM * 40 + 8;

    // one stimulus row with the relay vectors expected per port
    typedef struct packed {
        logic        new_slot;
        slot_id_t    slot;
        queue_snap_t snap;
        logic        offer0_valid;
        logic        offer1_valid;
        offer_t      offer0;
        offer_t      offer1;
        queue_vec_t  exp0;
        queue_vec_t  exp1;
    } test_row_t;

    logic        i_clk;
    logic        i_rst;
    logic        i_slot_start;
    slot_id_t    i_slot_id;
    logic        i_check_queue_resp_ready;
    queue_snap_t i_queue_snap;
    logic        i_offer0_valid;
    offer_t      i_offer0;
    logic        i_offer1_valid;
    offer_t      i_offer1;
    logic        o_check_queue_req_valid;
    logic        o_relay_valid;
    logic        o_relay_port;
    queue_vec_t  o_relay;

    test_row_t   rows [ROW_NUM];
    byte_cnt_t   model_budget [TOR_NUM];
    tor_id_t     model_a;
    tor_id_t     model_b;
    logic [31:0] rng_state = 32'h644f_8e53;
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          assert_errs;

    vlb_relay_ctrl u_vlb_relay_ctrl (
        .i_clk                    (i_clk),
        .i_rst                    (i_rst),
        .i_slot_start             (i_slot_start),
        .i_slot_id                (i_slot_id),
        .o_check_queue_req_valid  (o_check_queue_req_valid),
        .i_check_queue_resp_ready (i_check_queue_resp_ready),
        .i_queue_snap             (i_queue_snap),
        .i_offer0_valid           (i_offer0_valid),
        .i_offer0                 (i_offer0),
        .i_offer1_valid           (i_offer1_valid),
        .i_offer1                 (i_offer1),
        .o_relay_valid            (o_relay_valid),
        .o_relay_port             (o_relay_port),
        .o_relay                  (o_relay)
    );

    bind vlb_relay_ctrl vlb_relay_checker u_vlb_relay_checker (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req_valid   (o_check_queue_req_valid),
        .i_resp_ready  (i_check_queue_resp_ready),
        .i_relay_valid (o_relay_valid),
        .i_relay       (o_relay),
        .i_next_hop    (next_hop)
    );

    always #50 i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////
    // stimulus generation and reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic queue_snap_t random_snap();
        queue_snap_t s;
        for (int q = 0; q < TOR_NUM; q++) begin
            s.local_size[q]   = next_rand() & 32'h0000_ffff;
            s.unlocal_size[q] = next_rand() & 32'h0000_ffff;
        end
        return s;
    endfunction

    function automatic offer_t random_offer();
        offer_t o;
        for (int q = 0; q < TOR_NUM; q++) begin
            o.bytes[q] = next_rand() & 32'h0001_ffff;
        end
        o.capacity = next_rand() & 32'h0003_ffff;
        return o;
    endfunction

    // same size offered to every destination
    function automatic offer_t flat_offer(input byte_cnt_t size, input byte_cnt_t cap);
        offer_t o;
        for (int q = 0; q < TOR_NUM; q++) begin
            o.bytes[q] = size;
        end
        o.capacity = cap;
        return o;
    endfunction

    function automatic byte_cnt_t smallest(input byte_cnt_t x, input byte_cnt_t y,
                                           input byte_cnt_t z);
        byte_cnt_t m;
        m = x;
        if (y < m) begin
            m = y;
        end
        if (z < m) begin
            m = z;
        end
        return m;
    endfunction

    function automatic void load_model(input slot_id_t slot, input queue_snap_t snap);
        int     step;
        longint room;
        // neighbours of the slot after the captured one
        step    = 2 * ((int'(slot) + 1) % SLOT_NUM) + 1;
        model_a = tor_id_t'((MY_ID + step) % TOR_NUM);
        model_b = tor_id_t'((MY_ID + TOR_NUM - step) % TOR_NUM);
        for (int q = 0; q < TOR_NUM; q++) begin
            room = longint'(SLOT_MAX) - longint'(snap.local_size[q])
                 - longint'(snap.unlocal_size[q]);
            model_budget[q] = (room < 0) ? '0 : byte_cnt_t'(room);
        end
    endfunction

    function automatic queue_vec_t model_grant(input offer_t offer);
        byte_cnt_t  to_a;
        byte_cnt_t  to_b;
        queue_vec_t relay;
        to_a = smallest(offer.bytes[model_a], offer.capacity, model_budget[model_a]);
        to_b = smallest(offer.bytes[model_b], offer.capacity - to_a, model_budget[model_b]);
        model_budget[model_a] = model_budget[model_a] - to_a;
        model_budget[model_b] = model_budget[model_b] - to_b;
        relay          = '0;
        relay[model_a] = to_a;
        relay[model_b] = to_b;
        return relay;
    endfunction

    task automatic build_table();
        test_row_t r;
        for (int i = 0; i < ROW_NUM; i++) begin
            r        = '0;
            r.snap   = random_snap();
            r.offer0 = random_offer();
            r.offer1 = random_offer();
            case (i)
                0: begin
                    r.new_slot     = 1'b1;
                    r.offer0_valid = 1'b1;
                end
                // odd ocs grant cut by the capacity left over
                1: begin
                    r.offer0_valid    = 1'b1;
                    r.offer0.bytes[3] = 32'h0000_0100;
                    r.offer0.bytes[5] = 32'h0000_0300;
                    r.offer0.capacity = 32'h0000_0200;
                end
                2, 4: begin
                    r.offer0_valid = 1'b1;
                    r.offer0       = flat_offer(32'h0001_8000, 32'h0004_0000);
                end
                3: begin
                    r.offer1_valid = 1'b1;
                    r.offer1       = flat_offer(32'h0001_8000, 32'h0004_0000);
                end
                5: begin
                    r.new_slot     = 1'b1;
                    r.slot         = slot_id_t'(1);
                    r.offer1_valid = 1'b1;
                end
                7: begin
                    r.offer0_valid = 1'b1;
                    r.offer1_valid = 1'b1;
                    r.offer0       = flat_offer(32'h0002_8000, 32'h0005_0000);
                    r.offer1       = flat_offer(32'h0002_8000, 32'h0005_0000);
                end
                // queue 3 over budget, queue 5 almost full
                8: begin
                    r.new_slot             = 1'b1;
                    r.offer0_valid         = 1'b1;
                    r.snap.local_size[3]   = 32'h0003_0000;
                    r.snap.unlocal_size[3] = 32'h0002_0000;
                    r.snap.local_size[5]   = 32'h0003_ff00;
                    r.snap.unlocal_size[5] = 32'h0000_0000;
                end
                10: begin
                    r.new_slot     = 1'b1;
                    r.slot         = slot_id_t'(1);
                    r.offer0_valid = 1'b1;
                    r.offer1_valid = 1'b1;
                end
                default: begin
                    r.offer0_valid = 1'b1;
                    r.offer1_valid = 1'b1;
                end
            endcase
            if (r.new_slot) begin
                load_model(r.slot, r.snap);
            end
            // port 0 is served first
            if (r.offer0_valid) begin
                r.exp0 = model_grant(r.offer0);
            end
            if (r.offer1_valid) begin
                r.exp1 = model_grant(r.offer1);
            end
            rows[i] = r;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // driving and checking
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] expected);
        check_cnt++;
        if (got !== expected) begin
            err_cnt++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic take_snapshot(input slot_id_t slot, input queue_snap_t snap);
        @(negedge i_clk);
        i_slot_start = 1'b1;
        i_slot_id    = slot;
        i_queue_snap = snap;
        @(negedge i_clk);
        i_slot_start = 1'b0;
        while (o_check_queue_req_valid !== 1'b1) begin
            @(negedge i_clk);
        end
        // level holds while no response has come back
        @(negedge i_clk);
        check_value("o_check_queue_req_valid", 256'(o_check_queue_req_valid), 256'(1'b1));
        i_check_queue_resp_ready = 1'b1;
        while (o_check_queue_req_valid !== 1'b0) begin
            @(negedge i_clk);
        end
        i_check_queue_resp_ready = 1'b0;
        // synchroniser drains before the next slot
        repeat (4) @(negedge i_clk);
    endtask

    task automatic collect_result(input logic port, input queue_vec_t expected);
        while (o_relay_valid !== 1'b1) begin
            @(negedge i_clk);
        end
        check_value("o_relay_port", 256'(o_relay_port), 256'(port));
        check_value("o_relay", o_relay, expected);
        @(negedge i_clk);
    endtask

    task automatic apply_offers(input test_row_t r);
        @(negedge i_clk);
        i_offer0_valid = r.offer0_valid;
        i_offer0       = r.offer0;
        i_offer1_valid = r.offer1_valid;
        i_offer1       = r.offer1;
        @(negedge i_clk);
        i_offer0_valid = 1'b0;
        i_offer1_valid = 1'b0;
        if (r.offer0_valid) begin
            collect_result(1'b0, r.exp0);
        end
        if (r.offer1_valid) begin
            collect_result(1'b1, r.exp1);
        end
    endtask

    initial begin
        i_clk                    = 1'b0;
        i_rst                    = 1'b1;
        i_slot_start             = 1'b0;
        i_slot_id                = '0;
        i_check_queue_resp_ready = 1'b0;
        i_queue_snap             = '0;
        i_offer0_valid           = 1'b0;
        i_offer0                 = '0;
        i_offer1_valid           = 1'b0;
        i_offer1                 = '0;
        build_table();
        repeat (4) @(negedge i_clk);
        i_rst = 1'b0;
        check_value("o_check_queue_req_valid", 256'(o_check_queue_req_valid), 256'(1'b0));
        check_value("o_relay_valid", 256'(o_relay_valid), 256'(1'b0));
        for (int i = 0; i < ROW_NUM; i++) begin
            if (rows[i].new_slot) begin
                take_snapshot(rows[i].slot, rows[i].snap);
            end
            apply_offers(rows[i]);
        end
        repeat (2) @(negedge i_clk);
        assert_errs = u_vlb_relay_ctrl.u_vlb_relay_checker.assert_fail_cnt;
        $display("summary: %0d checks, %0d value errors, %0d assertion errors",
                 check_cnt, err_cnt, assert_errs);
        if (err_cnt == 0 && assert_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("timeout: the test sequence did not complete in %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/vlb_queue_pkg.sv
rtl/vlb_topo_pkg.sv
rtl/vlb_queue_snapshot.sv
rtl/vlb_next_hop.sv
rtl/vlb_offer_arbiter.sv
rtl/vlb_relay_alloc.sv
rtl/vlb_relay_ctrl.sv
sim/vlb_relay_checker.sv
sim/tb_vlb_relay_ctrl.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_vlb_relay_ctrl
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
RUN_ARGS  := +verilator+error+limit+1000
LOG       := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) rtl/vlb_params.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
